// ==== logic/mem_pkg.sv ====
/*
  shared widths, version word and bus structs of the data-memory path
  memory word is half the operand, base offset is added at ADDR_W width
*/
package mem_pkg;

	localparam int DATA_W    = 16;         // operand width
	localparam int HALF_W    = DATA_W / 2; // memory word width
	localparam int ADDR_W    = 8;          // data address width
	localparam int IM_ADDR_W = 4;          // immediate offset width

	// read-only word at register offset 0
	localparam logic [HALF_W-1:0] REG_VERSION = 8'h17;

	// access request from the core, one per cycle
	typedef struct packed {
		logic [DATA_W-1:0]    a;       // operand, source of write data
		logic [HALF_W-1:0]    b_lo;    // base offset
		logic [IM_ADDR_W-1:0] im_addr; // immediate offset
		logic [ADDR_W-1:0]    pc_1;    // next pc, fetch address
		logic                 wr;      // write
		logic                 rd;      // read
		logic                 ext;     // extended access
	} mem_req_t;

	// decoded command, fanned out to reg set, memory and return stage
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [HALF_W-1:0] wr_data;
		logic              regs_wr; // write into register space
		logic              regs_rd; // read from register space
		logic              dm_wr;   // write into data memory
		logic              rd;
		logic              ext;
		logic [HALF_W-1:0] a_lo;    // low operand half, for extended reads
	} mem_cmd_t;

	// result back to the core
	typedef struct packed {
		logic              rd_vld;
		logic [DATA_W-1:0] rd_data;
		logic              fetch_vld;
		logic [HALF_W-1:0] fetch_data;
	} mem_rtn_t;

endpackage

// ==== logic/vector_sr.sv ====
/*
  delay chain of REGS stages for any packed payload, zeroed on reset
  REGS of 0 gives a straight wire from data_i to data_o
*/
`timescale 1ns/10ps

module vector_sr #(
	parameter int  REGS      = 1,    // number of stages
	parameter type payload_t = logic // anything packed
) (
	input  logic     clk_i,
	input  logic     rst_i,  // sync, active high
	input  payload_t data_i,
	output payload_t data_o
);

	generate
		if (REGS == 0) begin : g_bypass
			assign data_o = data_i; // no stages
		end else begin : g_regs
			payload_t stage [REGS]; // stage[0] is nearest the input

			always_ff @(posedge clk_i) begin
				if (rst_i) begin
					for (int i = 0; i < REGS; i++) begin
						stage[i] <= '0;
					end
				end else begin
					stage[0] <= data_i;
					for (int i = 1; i < REGS; i++) begin
						stage[i] <= stage[i-1]; // shift toward output
					end
				end
			end

			assign data_o = stage[REGS-1];
		end
	endgenerate

endmodule

// ==== logic/reg_set_shim.sv ====
/*
  forms the access address and splits register space from data memory
  register set sits where all address bits above REG_ADDR_W are ones
  rd and wr must never be set together in one request
*/
`timescale 1ns/10ps

module reg_set_shim #(
	parameter int REGS_IN    = 1, // input stage depth
	parameter int REGS_OUT   = 1, // output stage depth
	parameter int REG_ADDR_W = 4  // register set span
) (
	input  logic               clk_i,
	input  logic               rst_i,
	input  mem_pkg::mem_req_t  req_i,
	output mem_pkg::mem_cmd_t  cmd_o
);

	import mem_pkg::*;

	mem_req_t          req;     // request after input stages
	mem_cmd_t          cmd;     // decoded, before output stages
	logic [ADDR_W-1:0] rw_addr; // data access address
	logic              rw;      // any data access at all
	logic              regs_en; // address lands in register space

	// optional input stages
	vector_sr #(
		.REGS      (REGS_IN),
		.payload_t (mem_req_t)
	) in_regs (
		.clk_i  (clk_i),
		.rst_i  (rst_i),
		.data_i (req_i),
		.data_o (req)
	);

	// base + immediate, wraps at 256
	assign rw_addr = ADDR_W'(req.b_lo) + ADDR_W'(req.im_addr);
	assign rw      = req.rd | req.wr;

	// no access means fetch at pc
	assign cmd.addr = rw ? rw_addr : req.pc_1;

	// top of the map belongs to the reg set
	assign regs_en = &cmd.addr[ADDR_W-1:REG_ADDR_W];

	assign cmd.regs_wr = req.wr & regs_en;
	assign cmd.regs_rd = req.rd & regs_en;
	assign cmd.dm_wr   = req.wr & ~regs_en; // reg writes never reach memory

	// ext writes store the high half
	assign cmd.wr_data = req.ext ? req.a[DATA_W-1:HALF_W] : req.a[HALF_W-1:0];

	// passed on for the return stage
	assign cmd.rd   = req.rd;
	assign cmd.ext  = req.ext;
	assign cmd.a_lo = req.a[HALF_W-1:0];

	// optional output stages
	vector_sr #(
		.REGS      (REGS_OUT),
		.payload_t (mem_cmd_t)
	) out_regs (
		.clk_i  (clk_i),
		.rst_i  (rst_i),
		.data_i (cmd),
		.data_o (cmd_o)
	);

	// core side contract, checked at the boundary
	a_no_rd_and_wr: assert property (
		@(posedge clk_i) disable iff (rst_i)
		!(req_i.rd && req_i.wr)
	) else $error("reg_set_shim: request with both rd and wr");

	// a write leaves the stages with exactly one write target
	a_one_wr_target: assert property (
		@(posedge clk_i) disable iff (rst_i)
		req_i.wr |-> ##(REGS_IN + REGS_OUT) (cmd_o.regs_wr ^ cmd_o.dm_wr)
	) else $error("reg_set_shim: write did not reach exactly one target");

endmodule

// ==== logic/reg_set.sv ====
/*
  register set, offset 0 version (read only), offset 1 data-memory write count
  offsets from 2 up are scratch, REG_ADDR_W must be 2 or more
  read data is registered, address bits above REG_ADDR_W are ignored
*/
`timescale 1ns/10ps

module reg_set #(
	parameter int REG_ADDR_W = 4 // register set span
) (
	input  logic                       clk_i,
	input  logic                       rst_i,
	input  mem_pkg::mem_cmd_t          cmd_i,
	output logic [mem_pkg::HALF_W-1:0] rd_data_o
);

	import mem_pkg::*;

	localparam int REGS_N = 2 ** REG_ADDR_W;

	localparam logic [REG_ADDR_W-1:0] OFS_VERSION = REG_ADDR_W'(0);
	localparam logic [REG_ADDR_W-1:0] OFS_WR_CNT  = REG_ADDR_W'(1);

	logic [REG_ADDR_W-1:0] offset;           // low address bits only
	logic [HALF_W-1:0]     wr_cnt;           // data memory write count
	logic [HALF_W-1:0]     scratch [REGS_N]; // entries 0 and 1 never written
	logic [HALF_W-1:0]     rd_word;
	logic                  scratch_wr;

	assign offset = cmd_i.addr[REG_ADDR_W-1:0];

	// version and counter offsets are read only
	assign scratch_wr = cmd_i.regs_wr && (offset != OFS_VERSION) && (offset != OFS_WR_CNT);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wr_cnt <= '0;
		end else if (cmd_i.dm_wr) begin
			wr_cnt <= wr_cnt + 1'b1; // wraps at 256
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int i = 0; i < REGS_N; i++) begin
				scratch[i] <= '0;
			end
		end else if (scratch_wr) begin
			scratch[offset] <= cmd_i.wr_data;
		end
	end

	// read mux
	always_comb begin
		case (offset)
			OFS_VERSION: rd_word = REG_VERSION;
			OFS_WR_CNT:  rd_word = wr_cnt;
			default:     rd_word = scratch[offset];
		endcase
	end

	// one cycle read latency, same as data_mem
	always_ff @(posedge clk_i) begin
		rd_data_o <= rd_word;
	end

	// the counter moves only after a memory write
	a_cnt_on_dm_wr: assert property (
		@(posedge clk_i) disable iff (rst_i)
		$changed(wr_cnt) |-> ($past(cmd_i.dm_wr) || $past(rst_i))
	) else $error("reg_set: write count changed without dm_wr");

endmodule

// ==== logic/data_mem.sv ====
/*
  single port main data memory, 2^ADDR_W words of HALF_W bits
  read data registered, a read colliding with a write returns the old word
  contents are not cleared by reset
*/
`timescale 1ns/10ps

module data_mem (
	input  logic                       clk_i,
	input  mem_pkg::mem_cmd_t          cmd_i,
	output logic [mem_pkg::HALF_W-1:0] rd_data_o
);

	import mem_pkg::*;

	localparam int WORDS = 2 ** ADDR_W;

	logic [HALF_W-1:0] mem [WORDS]; // storage

	// write port
	always_ff @(posedge clk_i) begin
		if (cmd_i.dm_wr) begin
			mem[cmd_i.addr] <= cmd_i.wr_data;
		end
	end

	// read every cycle, old data on collision
	always_ff @(posedge clk_i) begin
		rd_data_o <= mem[cmd_i.addr];
	end

endmodule

// ==== logic/rd_return.sv ====
/*
  lines up read flags with memory latency and forms the read and fetch result
  FILL_REGS is the shim stage depth; results stay quiet while reset zeros drain
  result is registered, one cycle after the read data
*/
`timescale 1ns/10ps

module rd_return #(
	parameter int FILL_REGS = 2 // REGS_IN + REGS_OUT of the shim
) (
	input  logic                       clk_i,
	input  logic                       rst_i,
	input  mem_pkg::mem_cmd_t          cmd_i,
	input  logic [mem_pkg::HALF_W-1:0] regs_rd_data_i,
	input  logic [mem_pkg::HALF_W-1:0] mem_rd_data_i,
	output mem_pkg::mem_rtn_t          rtn_o
);

	import mem_pkg::*;

	// flags travelling alongside the read data
	typedef struct packed {
		logic              rd;
		logic              fetch;   // neither rd nor wr
		logic              ext;
		logic              regs_rd;
		logic [HALF_W-1:0] a_lo;
	} align_t;

	logic              live;  // shim stages hold real requests
	logic              fetch; // no access this cycle
	align_t            aln;   // one cycle behind cmd_i
	logic [HALF_W-1:0] word;  // selected read word

	// ones shift in after reset, mirroring the shim stages
	vector_sr #(
		.REGS      (FILL_REGS),
		.payload_t (logic)
	) warm_sr (
		.clk_i  (clk_i),
		.rst_i  (rst_i),
		.data_i (1'b1),
		.data_o (live)
	);

	assign fetch = ~(cmd_i.rd | cmd_i.regs_wr | cmd_i.dm_wr);

	always_ff @(posedge clk_i) begin
		aln.ext     <= cmd_i.ext;
		aln.regs_rd <= cmd_i.regs_rd;
		aln.a_lo    <= cmd_i.a_lo;
		if (rst_i) begin
			aln.rd    <= 1'b0;
			aln.fetch <= 1'b0;
		end else begin
			aln.rd    <= cmd_i.rd & live;
			aln.fetch <= fetch & live;
		end
	end

	assign word = aln.regs_rd ? regs_rd_data_i : mem_rd_data_i; // source select

	always_ff @(posedge clk_i) begin
		// ext read packs word above a_lo, plain read sign extends
		rtn_o.rd_data    <= aln.ext ? {word, aln.a_lo} : {{HALF_W{word[HALF_W-1]}}, word};
		rtn_o.fetch_data <= mem_rd_data_i; // fetch always from memory
		if (rst_i) begin
			rtn_o.rd_vld    <= 1'b0;
			rtn_o.fetch_vld <= 1'b0;
		end else begin
			rtn_o.rd_vld    <= aln.rd;
			rtn_o.fetch_vld <= aln.fetch;
		end
	end

endmodule

// ==== logic/mem_subsys_top.sv ====
/*
  data-memory access path, no back-pressure, one request accepted per cycle
  result appears REGS_IN + REGS_OUT + 2 cycles after its request
  register set takes the top 2^REG_ADDR_W addresses
*/
`timescale 1ns/10ps

module mem_subsys_top #(
	parameter int REGS_IN    = 1, // shim input stages
	parameter int REGS_OUT   = 1, // shim output stages
	parameter int REG_ADDR_W = 4  // register set span
) (
	input  logic              clk_i,
	input  logic              rst_i, // sync, active high
	input  mem_pkg::mem_req_t req_i,
	output mem_pkg::mem_rtn_t rtn_o
);

	import mem_pkg::*;

	mem_cmd_t          cmd;          // decoded command
	logic [HALF_W-1:0] regs_rd_data; // from reg set
	logic [HALF_W-1:0] mem_rd_data;  // from data memory

	// address decode and stages
	reg_set_shim #(
		.REGS_IN    (REGS_IN),
		.REGS_OUT   (REGS_OUT),
		.REG_ADDR_W (REG_ADDR_W)
	) reg_set_shim_i (
		.clk_i (clk_i),
		.rst_i (rst_i),
		.req_i (req_i),
		.cmd_o (cmd)
	);

	// version, write count, scratch
	reg_set #(
		.REG_ADDR_W (REG_ADDR_W)
	) reg_set_i (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.cmd_i     (cmd),
		.rd_data_o (regs_rd_data)
	);

	// main memory, also the fetch source
	data_mem data_mem_i (
		.clk_i     (clk_i),
		.cmd_i     (cmd),
		.rd_data_o (mem_rd_data)
	);

	// result forming
	rd_return #(
		.FILL_REGS (REGS_IN + REGS_OUT)
	) rd_return_i (
		.clk_i          (clk_i),
		.rst_i          (rst_i),
		.cmd_i          (cmd),
		.regs_rd_data_i (regs_rd_data),
		.mem_rd_data_i  (mem_rd_data),
		.rtn_o          (rtn_o)
	);

endmodule

// ==== tests/mem_subsys_tb.sv ====
/*
  testbench for mem_subsys_top at default parameters, result latency 4 cycles
  inputs change and results are sampled on the falling edge
  read and fetch data are checked only where the contents are known
*/
`timescale 1ns/10ps

module mem_subsys_tb;

	import mem_pkg::*;

	localparam int LAT      = 4;    // REGS_IN + REGS_OUT + 2
	localparam int RST_CYC  = 16;
	localparam int WAIT_MAX = 2000; // cycles allowed per wait loop
	localparam logic [7:0] REG_BASE = 8'hf0; // register set starts here

	// one expected result
	typedef struct packed {
		logic              rd_vld;
		logic              rd_chk; // compare rd_data
		logic [DATA_W-1:0] rd_data;
		logic              fetch_vld;
		logic              fetch_chk;
		logic [HALF_W-1:0] fetch_data;
	} exp_t;

	logic     clk_i;
	logic     rst_i;
	mem_req_t req_i;
	mem_rtn_t rtn_o;

	mem_req_t          req_q [$];      // waiting to be issued
	exp_t              exp_line [LAT]; // [0] is newest
	exp_t              exp_head;
	logic [HALF_W-1:0] mem_shadow [256];
	bit                mem_known [256];
	logic [HALF_W-1:0] reg_shadow [16];
	logic [HALF_W-1:0] dm_wr_cnt;       // wraps like the real one
	logic [7:0]        written_q [$];   // data addresses holding known words
	int                cyc_cnt;
	int                issue_cnt;
	int                err_cnt;
	int                test_cnt;
	int                test_fail;
	time               rst_rel_time;

	mem_subsys_top mem_subsys_top_i (
		.clk_i (clk_i),
		.rst_i (rst_i),
		.req_i (req_i),
		.rtn_o (rtn_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;
	end

	function automatic logic [HALF_W-1:0] reg_word(input logic [3:0] ofs);
		if (ofs == 4'd0) return REG_VERSION;
		if (ofs == 4'd1) return dm_wr_cnt; // write count
		return reg_shadow[ofs];
	endfunction

	// reference model, one request per call in issue order
	task automatic model_step(input mem_req_t r, output exp_t e);
		logic [7:0]        addr;
		logic [HALF_W-1:0] word;
		e = '0;
		addr = (r.rd || r.wr) ? r.b_lo + 8'(r.im_addr) : r.pc_1;
		word = r.ext ? r.a[15:8] : r.a[7:0]; // write data
		if (r.wr && addr >= REG_BASE) begin
			if (addr[3:0] > 4'd1) reg_shadow[addr[3:0]] = word; // 0 and 1 read only
		end else if (r.wr) begin
			mem_shadow[addr] = word;
			mem_known[addr]  = 1'b1;
			dm_wr_cnt++;
		end else if (r.rd) begin
			word      = (addr >= REG_BASE) ? reg_word(addr[3:0]) : mem_shadow[addr];
			e.rd_vld  = 1'b1;
			e.rd_chk  = (addr >= REG_BASE) || mem_known[addr];
			e.rd_data = r.ext ? {word, r.a[7:0]} : {{8{word[7]}}, word};
		end else begin
			e.fetch_vld  = 1'b1; // fetch always comes from data memory
			e.fetch_chk  = mem_known[addr];
			e.fetch_data = mem_shadow[addr];
		end
	endtask

	// driver, owns rst_i and req_i, one request every cycle
	always @(negedge clk_i) begin
		mem_req_t r;
		exp_t     e;
		cyc_cnt++;
		r = '0; // idle is a fetch at pc 0
		e = '0;
		if (cyc_cnt < RST_CYC) begin
			rst_i = 1'b1;
		end else begin
			if (rst_i) rst_rel_time = $time;
			rst_i = 1'b0;
			if (req_q.size() > 0) r = req_q.pop_front();
			model_step(r, e);
			issue_cnt++;
		end
		req_i = r;
		for (int i = LAT - 1; i > 0; i--) exp_line[i] = exp_line[i-1];
		exp_line[0] = e;
	end

	assign exp_head = exp_line[LAT-1];

	a_rd_vld: assert property (@(negedge clk_i) rtn_o.rd_vld === exp_head.rd_vld)
		else begin
			err_cnt++;
			$display("FAIL %0t: rd_vld %b, expected %b", $time,
				$sampled(rtn_o.rd_vld), $sampled(exp_head.rd_vld));
		end
	a_fetch_vld: assert property (@(negedge clk_i) rtn_o.fetch_vld === exp_head.fetch_vld)
		else begin
			err_cnt++;
			$display("FAIL %0t: fetch_vld %b, expected %b", $time,
				$sampled(rtn_o.fetch_vld), $sampled(exp_head.fetch_vld));
		end
	a_rd_data: assert property (@(negedge clk_i) (exp_head.rd_vld && exp_head.rd_chk)
		|-> rtn_o.rd_data === exp_head.rd_data)
		else begin
			err_cnt++;
			$display("FAIL %0t: rd_data %h, expected %h", $time,
				$sampled(rtn_o.rd_data), $sampled(exp_head.rd_data));
		end
	a_fetch_data: assert property (@(negedge clk_i) (exp_head.fetch_vld && exp_head.fetch_chk)
		|-> rtn_o.fetch_data === exp_head.fetch_data)
		else begin
			err_cnt++;
			$display("FAIL %0t: fetch_data %h, expected %h", $time,
				$sampled(rtn_o.fetch_data), $sampled(exp_head.fetch_data));
		end

	function automatic mem_req_t mk_req(input bit wr, input bit rd, input bit ext,
		input logic [7:0] b, input logic [3:0] im, input logic [15:0] a, input logic [7:0] pc);
		mem_req_t r;
		r = '{a: a, b_lo: b, im_addr: im, pc_1: pc, wr: wr, rd: rd, ext: ext};
		return r;
	endfunction

	// random split of addr into base + immediate, wraps at 256
	function automatic mem_req_t data_req(input bit wr, input bit rd, input bit ext,
		input logic [7:0] addr, input logic [15:0] a);
		logic [3:0] im;
		im = 4'($urandom);
		return mk_req(wr, rd, ext, addr - 8'(im), im, a, 8'($urandom));
	endfunction

	function automatic mem_req_t fetch_req(input logic [7:0] pc);
		return mk_req(0, 0, 1'($urandom), 8'($urandom), 4'($urandom), 16'($urandom), pc);
	endfunction

	function automatic logic [7:0] known_addr();
		return written_q[$urandom_range(written_q.size() - 1, 0)];
	endfunction

	task automatic end_run(input bit timed_out);
		$display("tests %0d, failed %0d, requests %0d, errors %0d",
			test_cnt, test_fail, issue_cnt, err_cnt);
		if (!timed_out && err_cnt == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	endtask

	// queue empty, then let the last result come out
	task automatic wait_drain();
		int n;
		n = 0;
		while (req_q.size() != 0) begin
			@(negedge clk_i);
			n++;
			if (n > WAIT_MAX) begin
				$display("timeout: request queue did not drain in %0d cycles", WAIT_MAX);
				end_run(1'b1);
			end
		end
		repeat (LAT + 1) @(negedge clk_i);
	endtask

	task automatic report_test(input string name, input int errs_before);
		int n;
		n = err_cnt - errs_before;
		test_cnt++;
		if (n != 0) test_fail++;
		$display("test %0d %s: %s, %0d errors", test_cnt, name, (n == 0) ? "ok" : "bad", n);
	endtask

	initial begin
		int         e0;
		int         n;
		logic [7:0] addr;
		void'($urandom(32'hd203));
		rst_i     = 1'b1;
		req_i     = '0;
		dm_wr_cnt = '0;
		for (int i = 0; i < 16; i++) reg_shadow[i] = '0;
		for (int i = 0; i < LAT; i++) exp_line[i] = '0;

		// 1: queued during reset, first flag is the read, 2 + LAT after release
		e0 = err_cnt;
		req_q.push_back(data_req(1, 0, 0, 8'h00, 16'h0055)); // pc 0 for idle fetches
		req_q.push_back(data_req(1, 0, 0, 8'h10, 16'h00a3));
		req_q.push_back(data_req(0, 1, 0, 8'h10, 16'h0000));
		written_q.push_back(8'h00);
		written_q.push_back(8'h10);
		n = 0;
		while ((rtn_o.rd_vld | rtn_o.fetch_vld) !== 1'b1) begin
			@(negedge clk_i);
			n++;
			if (n > WAIT_MAX) begin
				$display("timeout: no valid result after reset");
				end_run(1'b1);
			end
		end
		a_first_lat: assert ($time == rst_rel_time + (2 + LAT) * 10 && rtn_o.rd_vld)
			else begin
				err_cnt++;
				$display("FAIL %0t: first valid result at wrong cycle", $time);
			end
		wait_drain();
		report_test("reset and first result", e0);

		// 2: write then read back to back, plain and extended, one wrapping address
		e0 = err_cnt;
		for (int i = 0; i < 16; i++) begin
			addr = 8'($urandom_range(8'hef, 1));
			req_q.push_back(data_req(1, 0, i[0], addr, 16'($urandom)));
			req_q.push_back(data_req(0, 1, i[0], addr, 16'($urandom)));
			written_q.push_back(addr);
		end
		req_q.push_back(mk_req(1, 0, 0, 8'hfe, 4'h5, 16'h00c4, 8'h00)); // lands on 0x03
		req_q.push_back(data_req(0, 1, 0, 8'h03, 16'h0000));
		written_q.push_back(8'h03);
		wait_drain();
		report_test("memory write and read", e0);

		// 3: scratch read back; version and counter ignore writes, counter proves no dm write
		e0 = err_cnt;
		for (int i = 2; i < 16; i++) begin
			req_q.push_back(data_req(1, 0, 1'($urandom), REG_BASE | 8'(i), 16'($urandom)));
		end
		for (int i = 2; i < 16; i++) req_q.push_back(data_req(0, 1, 0, REG_BASE | 8'(i), 0));
		req_q.push_back(data_req(1, 0, 0, 8'hf0, 16'($urandom)));
		req_q.push_back(data_req(1, 0, 1, 8'hf1, 16'($urandom)));
		req_q.push_back(data_req(0, 1, 0, 8'hf0, 0));
		req_q.push_back(data_req(0, 1, 1, 8'hf1, 16'($urandom)));
		wait_drain();
		report_test("register space", e0);

		// 4: enough memory writes to wrap the counter
		e0 = err_cnt;
		for (int i = 0; i < 300; i++) begin
			addr = 8'($urandom_range(8'h9f, 8'h20));
			req_q.push_back(data_req(1, 0, 1'($urandom), addr, 16'($urandom)));
			written_q.push_back(addr);
		end
		req_q.push_back(data_req(0, 1, 0, 8'hf1, 0));
		req_q.push_back(data_req(0, 1, 1, 8'hf1, 16'($urandom)));
		wait_drain();
		report_test("write counter", e0);

		// 5: fetches, including one right behind a write to the same word
		e0 = err_cnt;
		for (int i = 0; i < 12; i++) req_q.push_back(fetch_req(known_addr()));
		addr = known_addr();
		req_q.push_back(data_req(1, 0, 0, addr, 16'($urandom)));
		req_q.push_back(fetch_req(addr));
		wait_drain();
		report_test("fetch", e0);

		// 6: random mix, reads and fetches only on known words
		e0 = err_cnt;
		for (int i = 0; i < 400; i++) begin
			n = $urandom_range(2, 0);
			if (n == 0) begin
				addr = 8'($urandom);
				req_q.push_back(data_req(1, 0, 1'($urandom), addr, 16'($urandom)));
				if (addr < REG_BASE) written_q.push_back(addr);
			end else if (n == 1) begin
				addr = ($urandom_range(3, 0) == 0) ? REG_BASE | 8'($urandom_range(15, 0))
					: known_addr();
				req_q.push_back(data_req(0, 1, 1'($urandom), addr, 16'($urandom)));
			end else begin
				req_q.push_back(fetch_req(known_addr()));
			end
		end
		wait_drain();
		report_test("random mix", e0);

		end_run(1'b0);
	end

endmodule

// ==== sources.f ====
logic/mem_pkg.sv
logic/vector_sr.sv
logic/reg_set_shim.sv
logic/reg_set.sv
logic/data_mem.sv
logic/rd_return.sv
logic/mem_subsys_top.sv
tests/mem_subsys_tb.sv
